//--- include/sd_dat_params.svh
/*
 * Constants shared by the SD data-line controller.
 * Include this file wherever the widths, the CRC polynomial,
 * the status token or the timeout prescaler are needed.
 */
`ifndef SD_DAT_PARAMS_SVH
`define SD_DAT_PARAMS_SVH

// data path
`define SD_BYTE_W          8
`define SD_BLK_SIZE_W      12      // block size in bytes, 0 means one byte

// CRC16-CCITT, register starts at zero
`define SD_CRC_W           16
`define SD_CRC_POLY        16'h1021

// CRC status token sent by the card after a write block
`define SD_TOKEN_OK        3'b010

// timeout select and counters
`define SD_TMO_CFG_W       4
`define SD_TMO_PRESCALE_W  12      // one tick every 4096 clocks
`define SD_TMO_CNT_W       16

`endif

//--- rtl/sd_dat_pkg.sv
/*
 * Types for the SD data-line controller.
 * The transfer FSM states, and the per-cycle line opcode that the
 * FSM hands to the DAT0 line block.
 */
package sd_dat_pkg;

	typedef enum logic [3:0] {
		IDLE,
		WR_START,
		WR_DATA,
		WR_CRC,
		WR_END,
		TOKEN,     // CRC status token from the card
		BUSY,      // card holds DAT0 low while programming
		RD_WAIT,
		RD_DATA,
		RD_CRC,
		RD_END
	} dat_state_e;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_TX_START,
		PH_TX_DATA,
		PH_TX_CRC,
		PH_TX_END,
		PH_RX_DATA,
		PH_RX_CRC
	} dat_phase_e;

endpackage

//--- rtl/sd_crc16.sv
/*
 * Serial CRC16 for one SD data line.
 * calc_en folds data_bit into the register, shift_en streams the
 * result out MSB first on crc_bit. On receive, running data and the
 * received CRC through calc_en leaves zero in the register.
 */
`timescale 1ns/100ps
`include "sd_dat_params.svh"

module sd_crc16 (
	input  logic clk,
	input  logic rst,
	input  logic clear,
	input  logic calc_en,
	input  logic shift_en,
	input  logic data_bit,
	output logic crc_bit,
	output logic crc_zero
);

	logic [`SD_CRC_W-1:0] crc;
	logic                 fb;

	assign fb = crc[`SD_CRC_W-1] ^ data_bit;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			crc <= '0;
		else if (clear)
			crc <= '0;
		else if (calc_en)
			crc <= {crc[`SD_CRC_W-2:0], 1'b0} ^ ({`SD_CRC_W{fb}} & `SD_CRC_POLY);
		else if (shift_en)
			crc <= {crc[`SD_CRC_W-2:0], 1'b0};   // send MSB first
	end

	assign crc_bit  = crc[`SD_CRC_W-1];
	assign crc_zero = (crc == '0);

endmodule

//--- rtl/sd_dat_line.sv
/*
 * DAT0 line datapath.
 * Holds the transmit and receive shift registers and the CRC16.
 * The phase opcode from the FSM picks what goes on dat_out and
 * whether the line is driven. dat_in is sampled every clock.
 */
`timescale 1ns/100ps
`include "sd_dat_params.svh"

module sd_dat_line (
	input  logic                   clk,
	input  logic                   rst,
	input  sd_dat_pkg::dat_phase_e phase,
	input  logic                   load_byte,
	input  logic [`SD_BYTE_W-1:0]  tx_data,
	input  logic                   dat_in,
	output logic [`SD_BYTE_W-1:0]  rx_data,
	output logic                   rx_bit,
	output logic                   dat_out,
	output logic                   dat_oe,
	output logic                   crc_ok
);

	import sd_dat_pkg::*;

	logic [`SD_BYTE_W-1:0] tx_sr;
	logic [`SD_BYTE_W-1:0] rx_sr;
	logic                  crc_clear;
	logic                  crc_calc;
	logic                  crc_shift;
	logic                  crc_in;
	logic                  crc_bit;

	////////////////////////////////
	// transmit
	////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (load_byte)
			tx_sr <= tx_data;
		else if (phase == PH_TX_DATA)
			tx_sr <= {tx_sr[`SD_BYTE_W-2:0], 1'b0};
	end

	always_comb
	begin
		dat_oe  = 1'b1;
		dat_out = 1'b1;
		case (phase)
			PH_TX_START: dat_out = 1'b0;
			PH_TX_DATA:  dat_out = tx_sr[`SD_BYTE_W-1];
			PH_TX_CRC:   dat_out = crc_bit;
			PH_TX_END:   dat_out = 1'b1;
			default:     dat_oe  = 1'b0;   // line released to the card
		endcase
	end

	////////////////////////////////
	// receive
	////////////////////////////////

	// idle line reads high
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			rx_sr <= '1;
		else
			rx_sr <= {rx_sr[`SD_BYTE_W-2:0], dat_in};
	end

	assign rx_bit  = rx_sr[0];
	assign rx_data = rx_sr;

	////////////////////////////////
	// CRC
	////////////////////////////////

	assign crc_clear = (phase == PH_IDLE);
	assign crc_calc  = (phase == PH_TX_DATA) || (phase == PH_RX_DATA) || (phase == PH_RX_CRC);
	assign crc_shift = (phase == PH_TX_CRC);
	assign crc_in    = (phase == PH_TX_DATA) ? tx_sr[`SD_BYTE_W-1] : rx_bit;

	sd_crc16 crc_i (
		.clk      (clk),
		.rst      (rst),
		.clear    (crc_clear),
		.calc_en  (crc_calc),
		.shift_en (crc_shift),
		.data_bit (crc_in),
		.crc_bit  (crc_bit),
		.crc_zero (crc_ok)
	);

endmodule

//--- rtl/sd_dat_timer.sv
/*
 * Shared byte and timeout counter.
 * During data it counts block bytes on byte_tick. While tmo_run is
 * high it runs as a 4096 clock prescaler feeding a tick counter,
 * and timeout_cfg picks which tick counter bit ends the wait.
 */
`timescale 1ns/100ps
`include "sd_dat_params.svh"

module sd_dat_timer (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       clear,
	input  logic                       byte_tick,
	input  logic                       tmo_run,
	input  logic [`SD_BLK_SIZE_W-1:0]  block_size,
	input  logic [`SD_TMO_CFG_W-1:0]   timeout_cfg,
	output logic                       last_byte,
	output logic                       timeout
);

	logic [`SD_BLK_SIZE_W-1:0] shared_cnt;
	logic [`SD_TMO_CNT_W-1:0]  tmo_cnt;
	logic                      prescale_wrap;

	assign prescale_wrap = &shared_cnt[`SD_TMO_PRESCALE_W-1:0];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			shared_cnt <= {{(`SD_BLK_SIZE_W-1){1'b0}}, 1'b1};
			tmo_cnt    <= '0;
		end
		else if (clear)
		begin
			shared_cnt <= {{(`SD_BLK_SIZE_W-1){1'b0}}, 1'b1};   // bytes count from one
			tmo_cnt    <= '0;
		end
		else
		begin
			if (byte_tick || tmo_run)
				shared_cnt <= shared_cnt + 1'b1;
			if (tmo_run && prescale_wrap && !timeout)
				tmo_cnt <= tmo_cnt + 1'b1;   // holds once expired
		end
	end

	assign last_byte = (shared_cnt == block_size) || (block_size == '0);

	// 2^(cfg+1) ticks, top setting saturates at the last bit
	always_comb
	begin
		if (&timeout_cfg)
			timeout = tmo_cnt[`SD_TMO_CNT_W-1];
		else
			timeout = tmo_cnt[timeout_cfg + 1'b1];
	end

endmodule

//--- rtl/sd_dat_fsm.sv
/*
 * Transfer FSM for one data block on DAT0.
 * Sequences the write path (start, data, CRC, end, status token,
 * busy) and the read path (start wait, data, CRC, end bit), drives
 * the buffer strobes and keeps sticky error flags until the next start.
 */
`timescale 1ns/100ps
`include "sd_dat_params.svh"

module sd_dat_fsm (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic                   data_dir,
	input  logic                   buffer_rdy,
	input  logic                   rx_bit,
	input  logic                   last_byte,
	input  logic                   timeout,
	input  logic                   crc_ok,
	input  logic [`SD_BYTE_W-1:0]  rx_data,
	output sd_dat_pkg::dat_phase_e phase,
	output logic                   tmr_clear,
	output logic                   byte_tick,
	output logic                   tmo_run,
	output logic                   load_byte,
	output logic                   pop_data,
	output logic                   push_data,
	output logic                   busy,
	output logic                   done,
	output logic                   crc_error,
	output logic                   end_error,
	output logic                   timeout_error
);

	import sd_dat_pkg::*;

	dat_state_e state;
	dat_state_e state_nxt;
	logic [3:0] bit_cnt;
	logic [3:0] bit_cnt_nxt;
	logic       go;
	logic       byte_end;
	logic       to_idle;
	logic       set_crc_err;
	logic       set_end_err;
	logic       set_tmo_err;

	assign go       = start | busy;   // new request or one waiting in IDLE
	assign byte_end = (bit_cnt[2:0] == 3'd7);
	assign to_idle  = (state != IDLE) && (state_nxt == IDLE);

	always_comb
	begin
		state_nxt   = state;
		bit_cnt_nxt = bit_cnt + 1'b1;
		set_crc_err = 1'b0;
		set_end_err = 1'b0;
		set_tmo_err = 1'b0;
		case (state)
			IDLE:
			begin
				bit_cnt_nxt = '0;
				if (go && data_dir)
					state_nxt = RD_WAIT;
				else if (go && buffer_rdy && rx_bit)
					state_nxt = WR_START;
			end
			WR_START:
			begin
				bit_cnt_nxt = '0;
				state_nxt   = WR_DATA;
			end
			WR_DATA, RD_DATA:
			begin
				if (byte_end)
				begin
					bit_cnt_nxt = '0;
					if (last_byte)
						state_nxt = (state == WR_DATA) ? WR_CRC : RD_CRC;
				end
			end
			WR_CRC:
				if (&bit_cnt)
					state_nxt = WR_END;
			WR_END:
			begin
				bit_cnt_nxt = '0;
				state_nxt   = TOKEN;
			end
			TOKEN:
			begin
				if (bit_cnt == 4'd0 && rx_bit)
					bit_cnt_nxt = '0;   // waiting for the token start bit
				else if (bit_cnt == 4'd4)
				begin
					bit_cnt_nxt = '0;
					state_nxt   = BUSY;
					set_crc_err = (rx_data[3:1] != `SD_TOKEN_OK);
					set_end_err = !rx_data[0];
				end
			end
			BUSY, RD_WAIT:
			begin
				bit_cnt_nxt = '0;
				if (state == BUSY && rx_bit)
					state_nxt = IDLE;   // card released busy
				else if (state == RD_WAIT && !rx_bit)
					state_nxt = RD_DATA;
				else if (timeout)
				begin
					state_nxt   = IDLE;
					set_tmo_err = 1'b1;
				end
			end
			RD_CRC:
				if (&bit_cnt)
					state_nxt = RD_END;
			RD_END:
			begin
				bit_cnt_nxt = '0;
				state_nxt   = IDLE;
				set_crc_err = !crc_ok;
				set_end_err = !rx_bit;
			end
			default:
			begin
				bit_cnt_nxt = '0;
				state_nxt   = IDLE;
			end
		endcase
	end

	always_comb
	begin
		case (state)
			WR_START: phase = PH_TX_START;
			WR_DATA:  phase = PH_TX_DATA;
			WR_CRC:   phase = PH_TX_CRC;
			WR_END:   phase = PH_TX_END;
			RD_DATA:  phase = PH_RX_DATA;
			RD_CRC:   phase = PH_RX_CRC;
			default:  phase = PH_IDLE;
		endcase
	end

	assign tmr_clear = (state == IDLE) || (state == TOKEN) || (state == RD_WAIT && !rx_bit);
	assign tmo_run   = (state == RD_WAIT) || (state == BUSY);
	assign byte_tick = (state == WR_DATA || state == RD_DATA) && byte_end;
	assign load_byte = (state == WR_START) || (state == WR_DATA && byte_end && !last_byte);
	assign pop_data  = load_byte;
	assign push_data = (state == RD_DATA) && byte_end;   // eighth bit sits in rx_data

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state         <= IDLE;
			bit_cnt       <= '0;
			busy          <= 1'b0;
			done          <= 1'b0;
			crc_error     <= 1'b0;
			end_error     <= 1'b0;
			timeout_error <= 1'b0;
		end
		else
		begin
			state   <= state_nxt;
			bit_cnt <= bit_cnt_nxt;
			done    <= to_idle;
			if (start && !busy)
			begin
				busy          <= 1'b1;
				crc_error     <= 1'b0;
				end_error     <= 1'b0;
				timeout_error <= 1'b0;
			end
			else
			begin
				if (to_idle)
					busy <= 1'b0;
				if (set_crc_err)
					crc_error <= 1'b1;
				if (set_end_err)
					end_error <= 1'b1;
				if (set_tmo_err)
					timeout_error <= 1'b1;
			end
		end
	end

endmodule

//--- rtl/sd_dat_ctrl.sv
/*
 * SD host data-line controller, one-bit bus mode.
 * A start pulse moves one block on DAT0 in the direction given by
 * data_dir. Bytes come from and go to an external buffer through
 * pop_data and push_data, and done closes each transfer.
 */
`timescale 1ns/100ps
`include "sd_dat_params.svh"

module sd_dat_ctrl (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  logic                       data_dir,
	input  logic                       buffer_rdy,
	input  logic                       dat_in,
	input  logic [`SD_BLK_SIZE_W-1:0]  block_size,
	input  logic [`SD_TMO_CFG_W-1:0]   timeout_cfg,
	input  logic [`SD_BYTE_W-1:0]      tx_data,
	output logic [`SD_BYTE_W-1:0]      rx_data,
	output logic                       pop_data,
	output logic                       push_data,
	output logic                       busy,
	output logic                       done,
	output logic                       crc_error,
	output logic                       end_error,
	output logic                       timeout_error,
	output logic                       dat_out,
	output logic                       dat_oe
);

	import sd_dat_pkg::*;

	dat_phase_e phase;
	logic       tmr_clear;
	logic       byte_tick;
	logic       tmo_run;
	logic       load_byte;
	logic       last_byte;
	logic       timeout;
	logic       rx_bit;
	logic       crc_ok;

	sd_dat_fsm fsm_i (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.data_dir      (data_dir),
		.buffer_rdy    (buffer_rdy),
		.rx_bit        (rx_bit),
		.last_byte     (last_byte),
		.timeout       (timeout),
		.crc_ok        (crc_ok),
		.rx_data       (rx_data),
		.phase         (phase),
		.tmr_clear     (tmr_clear),
		.byte_tick     (byte_tick),
		.tmo_run       (tmo_run),
		.load_byte     (load_byte),
		.pop_data      (pop_data),
		.push_data     (push_data),
		.busy          (busy),
		.done          (done),
		.crc_error     (crc_error),
		.end_error     (end_error),
		.timeout_error (timeout_error)
	);

	// byte count during data, prescaled ticks during waits
	sd_dat_timer timer_i (
		.clk         (clk),
		.rst         (rst),
		.clear       (tmr_clear),
		.byte_tick   (byte_tick),
		.tmo_run     (tmo_run),
		.block_size  (block_size),
		.timeout_cfg (timeout_cfg),
		.last_byte   (last_byte),
		.timeout     (timeout)
	);

	sd_dat_line line_i (
		.clk       (clk),
		.rst       (rst),
		.phase     (phase),
		.load_byte (load_byte),
		.tx_data   (tx_data),
		.dat_in    (dat_in),
		.rx_data   (rx_data),
		.rx_bit    (rx_bit),
		.dat_out   (dat_out),
		.dat_oe    (dat_oe),
		.crc_ok    (crc_ok)
	);

endmodule

//--- verification/sd_card_model.sv
/*
 * Behavioral SD card on DAT0 for the controller testbench.
 * Captures the host's write block, answers it with a CRC status
 * token and a busy period, and sends a read block when rd_go is seen.
 * The line is watched on the falling clock edge, and dat_in changes
 * just after the rising edge.
 */
`timescale 1ns/100ps
`include "sd_dat_params.svh"

module sd_card_model (
	input  logic        clk,
	input  logic        rst,
	input  logic        dat_out,
	input  logic        dat_oe,
	input  logic        token_bad,
	input  logic        rd_go,
	input  logic        rd_crc_bad,
	input  logic        rd_end_bad,
	input  logic [3:0]  rd_len,
	input  logic [63:0] rd_block,
	input  logic [15:0] rd_crc,
	output logic        dat_in,
	output logic [63:0] wr_bits,
	output logic [7:0]  wr_cnt
);

	logic oe_q;

	// one bit per clock, launched just after the rising edge
	task send_bit(input logic b);
		@(posedge clk);
		#1;
		dat_in = b;
	endtask

	// start bit, token, end bit, then busy
	task write_response;
		logic [2:0] tok;
		int         i;
		begin
			tok = token_bad ? 3'b101 : `SD_TOKEN_OK;
			repeat (2) @(negedge clk);
			send_bit(1'b0);
			for (i = 2; i >= 0; i--)
				send_bit(tok[i]);
			send_bit(1'b1);
			repeat (10) send_bit(1'b0);
			send_bit(1'b1);
		end
	endtask

	task read_block;
		logic [15:0] crc;
		int          i;
		begin
			crc = rd_crc ^ (rd_crc_bad ? 16'h0001 : 16'h0000);   // one flipped bit
			repeat (3) @(negedge clk);
			send_bit(1'b0);
			for (i = 0; i < rd_len * 8; i++)
				send_bit(rd_block[63 - i]);
			for (i = 15; i >= 0; i--)
				send_bit(crc[i]);
			send_bit(!rd_end_bad);
			send_bit(1'b1);
		end
	endtask

	initial
	begin
		dat_in  = 1'b1;
		oe_q    = 1'b0;
		wr_bits = '0;
		wr_cnt  = '0;
		forever
		begin
			@(negedge clk);
			if (rst)
				oe_q = 1'b0;
			else if (dat_oe)
			begin
				if (!oe_q)
				begin
					wr_cnt  = '0;   // new block
					wr_bits = '0;
				end
				wr_bits = {wr_bits[62:0], dat_out};
				wr_cnt  = wr_cnt + 1'b1;
				oe_q    = 1'b1;
			end
			else if (oe_q)
			begin
				oe_q = 1'b0;
				write_response();
			end
			else if (rd_go)
				read_block();
		end
	end

endmodule

//--- verification/sd_dat_ctrl_tb.sv
/*
 * Testbench for the SD data-line controller.
 * Runs writes and reads against the card model, checks line bits,
 * buffer strobes and error flags, and reports one line per test.
 */
`timescale 1ns/100ps
`include "sd_dat_params.svh"

module sd_dat_ctrl_tb;

	localparam int CYCLE_LIMIT = 40000;
	localparam int DONE_LIMIT  = 400;

	logic                      clk = 1'b0;
	logic                      rst;
	logic                      start;
	logic                      data_dir;
	logic                      buffer_rdy;
	logic                      dat_in;
	logic [`SD_BLK_SIZE_W-1:0] block_size;
	logic [`SD_TMO_CFG_W-1:0]  timeout_cfg;
	logic [`SD_BYTE_W-1:0]     tx_data;
	logic [`SD_BYTE_W-1:0]     rx_data;
	logic                      pop_data;
	logic                      push_data;
	logic                      busy;
	logic                      done;
	logic                      crc_error;
	logic                      end_error;
	logic                      timeout_error;
	logic                      dat_out;
	logic                      dat_oe;

	logic        token_bad;
	logic        rd_go;
	logic        rd_crc_bad;
	logic        rd_end_bad;
	logic [3:0]  rd_len;
	logic [63:0] rd_block;
	logic [15:0] rd_crc;
	logic [63:0] wr_bits;
	logic [7:0]  wr_cnt;

	logic [63:0] wr_blk;
	logic [7:0]  rx_q[$];
	int          pop_cnt = 0;
	int          pop_base = 0;
	int          cycles = 0;
	int          errors = 0;
	int          tests = 0;
	int          test_fails = 0;
	int          err_mark;
	int          i;

	sd_dat_ctrl sd_dat_ctrl_i (.*);

	sd_card_model card_i (.*);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// transmit buffer shows the next byte after each pop
	always @(posedge clk)
	begin
		#1;
		tx_data = wr_blk[63 - 8 * ((pop_cnt - pop_base) & 7) -: 8];
	end

	always @(negedge clk)
	begin
		if (pop_data)
			pop_cnt++;
		if (push_data)
			rx_q.push_back(rx_data);
	end

	////////////////////////////////
	// assertions

	assert property (@(posedge clk) disable iff (rst) dat_oe |-> (busy && !data_dir))
	else
	begin
		$display("Error: %0t ns dat_oe expected 0 got 1", $time);
		errors++;
	end
	assert property (@(posedge clk) disable iff (rst) done |-> !busy)
	else
	begin
		$display("Error: %0t ns busy expected 0 got 1", $time);
		errors++;
	end
	assert property (@(posedge clk) disable iff (rst) (pop_data || push_data) |-> busy)
	else
	begin
		$display("Error: %0t ns busy expected 1 got 0", $time);
		errors++;
	end

	////////////////////////////////

	function automatic logic [15:0] crc16_ref(input logic [63:0] blk, input int n);
		logic [15:0] crc;
		logic        fb;
		int          k;
		crc = '0;
		for (k = 0; k < n * 8; k++)
		begin
			fb  = crc[15] ^ blk[63 - k];
			crc = {crc[14:0], 1'b0} ^ (fb ? `SD_CRC_POLY : 16'h0000);
		end
		return crc;
	endfunction

	task tick;
		@(posedge clk);
		#1;
	endtask

	task check_value(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			$display("Error: %0t ns %s expected %0h got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task wait_done(input int limit);
		int  n;
		bit  seen;
		n    = 0;
		seen = 0;
		while (!seen && n < limit)
		begin
			@(negedge clk);
			seen = done;
			n++;
		end
		if (!seen)
		begin
			$display("done did not pulse within %0d cycles", limit);
			errors++;
		end
		tick();
	endtask

	task start_transfer(input logic dir, input int nbytes);
		data_dir   = dir;
		block_size = nbytes;
		start      = 1'b1;
		tick();
		start      = 1'b0;
		rd_go      = 1'b0;
		check_value("busy", busy, 1);
	endtask

	task run_write(input int nbytes, input logic bad_tok);
		logic [63:0] exp;
		logic [63:0] mask;
		logic [15:0] crc;
		int          len;
		int          k;
		wr_blk    = {$urandom, $urandom};
		crc       = crc16_ref(wr_blk, nbytes);
		token_bad = bad_tok;
		pop_base  = pop_cnt;
		tick();
		start_transfer(1'b0, nbytes);
		wait_done(DONE_LIMIT);
		len = 2 + 8 * nbytes + 16;
		exp = '0;
		for (k = 0; k < 8 * nbytes; k++)
			exp = {exp[62:0], wr_blk[63 - k]};
		exp  = {exp[46:0], crc, 1'b1};   // start bit 0 is already above
		mask = (64'd1 << len) - 1;
		check_value("pop_data count", pop_cnt - pop_base, nbytes);
		check_value("bit count on dat_out", wr_cnt, len);
		assert ((wr_bits & mask) == (exp & mask))
		else
		begin
			$display("Error: %0t ns dat_out expected %0h got %0h",
			         $time, exp & mask, wr_bits & mask);
			errors++;
		end
	endtask

	task run_read(input logic bad_crc, input logic bad_end);
		rd_block   = {$urandom, $urandom};
		rd_len     = 4'd8;
		rd_crc     = crc16_ref(rd_block, 8);
		rd_crc_bad = bad_crc;
		rd_end_bad = bad_end;
		rx_q.delete();
		rd_go      = 1'b1;
		start_transfer(1'b1, 8);
		wait_done(DONE_LIMIT);
		check_value("push_data count", rx_q.size(), 8);
		for (i = 0; i < rx_q.size() && i < 8; i++)
			check_value("rx_data", rx_q[i], rd_block[63 - 8 * i -: 8]);
	endtask

	task end_test(input string name);
		tests++;
		if (errors != err_mark)
		begin
			test_fails++;
			$display("test %0d %s: failed", tests, name);
		end
		else
			$display("test %0d %s: ok", tests, name);
		err_mark = errors;
	endtask

	task check_flags(input int c, input int e, input int t);
		check_value("crc_error", crc_error, c);
		check_value("end_error", end_error, e);
		check_value("timeout_error", timeout_error, t);
	endtask

	initial
	begin
		void'($urandom(87));
		rst = 1'b1;
		start = 1'b0;
		data_dir = 1'b0;
		buffer_rdy = 1'b1;
		block_size = '0;
		timeout_cfg = 4'd4;
		tx_data = '0;
		wr_blk = '0;
		token_bad = 1'b0;
		rd_go = 1'b0;
		rd_crc_bad = 1'b0;
		rd_end_bad = 1'b0;
		rd_len = '0;
		rd_block = '0;
		rd_crc = '0;
		err_mark = 0;
		repeat (4) tick();
		rst = 1'b0;
		tick();

		check_value("busy", busy, 0);
		check_value("done", done, 0);
		check_value("dat_oe", dat_oe, 0);
		check_value("pop_data", pop_data, 0);
		check_value("push_data", push_data, 0);
		check_value("dat_out", dat_out, 1);
		check_flags(0, 0, 0);
		end_test("reset state");

		run_write(4, 1'b0);
		check_flags(0, 0, 0);
		end_test("4 byte write");

		run_write(4, 1'b1);
		check_flags(1, 0, 0);
		run_write(4, 1'b0);
		check_flags(0, 0, 0);
		end_test("bad token then clean write");

		run_read(1'b0, 1'b0);
		check_flags(0, 0, 0);
		end_test("8 byte read");

		run_read(1'b1, 1'b0);
		check_flags(1, 0, 0);
		run_read(1'b0, 1'b1);
		check_flags(0, 1, 0);
		end_test("read crc and end bit errors");

		timeout_cfg = 4'd0;   // 2 ticks of 4096 clocks
		start_transfer(1'b1, 8);
		wait_done(8192 + 300);
		check_value("busy", busy, 0);
		check_flags(0, 0, 1);
		end_test("read timeout");

		$display("tests %0d, failed %0d, errors %0d", tests, test_fails, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- sd_dat_ctrl.f
+incdir+include
rtl/sd_dat_pkg.sv
rtl/sd_crc16.sv
rtl/sd_dat_line.sv
rtl/sd_dat_timer.sv
rtl/sd_dat_fsm.sv
rtl/sd_dat_ctrl.sv
verification/sd_card_model.sv
verification/sd_dat_ctrl_tb.sv

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sd_dat_ctrl.f --top-module sd_dat_ctrl_tb -o sd_dat_ctrl_sim

output="$(./obj_dir/sd_dat_ctrl_sim)"
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
	exit 0
fi
exit 1
